// ==== rv32i_defs.svh ====
/* RV32I core constants */
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

`define XLEN        32
`define REG_ADDR_W  5

// Major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111

`define F3_ADD      3'b000  // Also SUB with funct7 bit 5
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101  // SRL or SRA
`define F3_OR       3'b110
`define F3_AND      3'b111

`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`define RESET_PC    32'h0000_0000

`endif

// ==== rv32i_pkg.sv ====
/* RV32I instruction and control types */
`include "rv32i_defs.svh"

package rv32i_pkg;

  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]            imm_11_0;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]             imm_11_5;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [4:0]             imm_4_0;
    logic [6:0]             opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                   imm_12;
    logic [5:0]             imm_10_5;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [3:0]             imm_4_1;
    logic                   imm_11;
    logic [6:0]             opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]            imm_31_12;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                   imm_20;
    logic [9:0]             imm_10_1;
    logic                   imm_11;
    logic [7:0]             imm_19_12;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } j_fmt_t;

  // One fetched word seen through every encoding format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;

  typedef enum logic [1:0] {JUMP_NONE, JUMP_BRANCH, JUMP_JUMP} jump_e;

endpackage

// ==== decode_if.sv ====
/* Decoded control bundle */
`timescale 1ns/1ps
`include "rv32i_defs.svh"

interface decode_if
  import rv32i_pkg::*;
();

  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`REG_ADDR_W-1:0] rd_addr;    // Zero when nothing is written
  logic [`XLEN-1:0]       imm;
  alu_op_e                alu_op;
  logic                   op1_pc;     // Operand 1 is pc
  logic                   op2_imm;    // Operand 2 is the immediate
  jump_e                  jump;
  logic [2:0]             branch_f3;
  wb_sel_e                wb_sel;
  logic                   rf_wen;
  logic                   mem_write;

  modport decoder (output rs1_addr, rs2_addr, rd_addr, imm, alu_op, op1_pc, op2_imm,
                   jump, branch_f3, wb_sel, rf_wen, mem_write);

  modport executor (input imm, alu_op, op1_pc, op2_imm, jump, branch_f3);

  modport writeback (input rs1_addr, rs2_addr, rd_addr, wb_sel, rf_wen, mem_write);

endinterface

// ==== rv32i_decoder.sv ====
/* RV32I instruction decoder */
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module rv32i_decoder
  import rv32i_pkg::*;
(
  input  instr_u    instr,
  decode_if.decoder dec
);

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  // funct3 to ALU op, alt is instruction bit 30
  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt,
                                          input logic is_reg);
    alu_op_e op;
    op = ALU_ADD;
    case (f3)
      `F3_ADD:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;  // ADDI has no SUB form
      `F3_SLL:  op = ALU_SLL;
      `F3_SLT:  op = ALU_SLT;
      `F3_SLTU: op = ALU_SLTU;
      `F3_XOR:  op = ALU_XOR;
      `F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      `F3_OR:   op = ALU_OR;
      `F3_AND:  op = ALU_AND;
      default:  op = ALU_ADD;
    endcase
    return op;
  endfunction

  // Sign extended immediates, one per format view
  assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
  assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
  assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                  instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
  assign imm_u = {instr.u.imm_31_12, 12'h000};
  assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                  instr.j.imm_11, instr.j.imm_10_1, 1'b0};

  always_comb begin
    dec.rs1_addr  = instr.r.rs1;
    dec.rs2_addr  = instr.r.rs2;
    dec.rd_addr   = instr.r.rd;
    dec.imm       = imm_i;
    dec.alu_op    = ALU_ADD;
    dec.op1_pc    = 1'b0;
    dec.op2_imm   = 1'b1;
    dec.jump      = JUMP_NONE;
    dec.branch_f3 = instr.b.funct3;
    dec.wb_sel    = WB_ALU;
    dec.rf_wen    = 1'b0;
    dec.mem_write = 1'b0;
    case (instr.r.opcode)
      `OPC_OP: begin
        dec.op2_imm = 1'b0;
        dec.alu_op  = alu_from_f3(instr.r.funct3, instr.r.funct7[5], 1'b1);
        dec.rf_wen  = 1'b1;
      end
      `OPC_OP_IMM: begin
        dec.alu_op = alu_from_f3(instr.i.funct3, instr.r.funct7[5], 1'b0);
        dec.rf_wen = 1'b1;
      end
      `OPC_LOAD: begin                 // Always a word load
        dec.wb_sel = WB_MEM;
        dec.rf_wen = 1'b1;
      end
      `OPC_STORE: begin
        dec.imm       = imm_s;
        dec.mem_write = 1'b1;
        dec.rd_addr   = '0;
      end
      `OPC_BRANCH: begin
        dec.imm     = imm_b;
        dec.op1_pc  = 1'b1;            // ALU forms the target
        dec.jump    = JUMP_BRANCH;
        dec.rd_addr = '0;
      end
      `OPC_LUI: begin
        dec.imm    = imm_u;
        dec.alu_op = ALU_PASS_B;
        dec.rf_wen = 1'b1;
      end
      `OPC_AUIPC: begin
        dec.imm    = imm_u;
        dec.op1_pc = 1'b1;
        dec.rf_wen = 1'b1;
      end
      `OPC_JAL: begin
        dec.imm    = imm_j;
        dec.op1_pc = 1'b1;
        dec.jump   = JUMP_JUMP;
        dec.wb_sel = WB_LINK;
        dec.rf_wen = 1'b1;
      end
      `OPC_JALR: begin
        dec.jump   = JUMP_JUMP;
        dec.wb_sel = WB_LINK;
        dec.rf_wen = 1'b1;
      end
      default: dec.rd_addr = '0;       // FENCE, ECALL and unknown words
    endcase
  end

endmodule

// ==== rv32i_executor.sv ====
/* RV32I ALU and branch unit */
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module rv32i_executor
  import rv32i_pkg::*;
(
  decode_if.executor       dec,
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  output logic [`XLEN-1:0] alu_result,
  output logic             taken
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [4:0]       shamt;
  logic             cond;
  logic             lt_signed;
  logic             lt_unsigned;

  assign op_a  = dec.op1_pc ? pc : rs1_data;
  assign op_b  = dec.op2_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];  // Low five bits only

  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  // Result doubles as memory address and jump target
  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_SLL:    alu_result = op_a << shamt;
      ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   alu_result = {{(`XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SRL:    alu_result = op_a >> shamt;
      ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
      ALU_OR:     alu_result = op_a | op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_PASS_B: alu_result = op_b;   // LUI
      default:    alu_result = op_a + op_b;
    endcase
  end

  // Compare always on the register values, not the selected operands
  always_comb begin
    case (dec.branch_f3)
      `F3_BEQ:  cond = rs1_data == rs2_data;
      `F3_BNE:  cond = rs1_data != rs2_data;
      `F3_BLT:  cond = $signed(rs1_data) < $signed(rs2_data);
      `F3_BGE:  cond = $signed(rs1_data) >= $signed(rs2_data);
      `F3_BLTU: cond = rs1_data < rs2_data;
      `F3_BGEU: cond = rs1_data >= rs2_data;
      default:  cond = 1'b0;           // Reserved encodings fall through
    endcase
  end

  assign taken = (dec.jump == JUMP_JUMP) || ((dec.jump == JUMP_BRANCH) && cond);

  // Known pc means reset has released and fetch is valid
  always_comb begin
    if (!$isunknown(pc)) begin
      assert (!$isunknown(dec.alu_op))
        else $error("executor: alu_op unknown at pc %h", pc);
    end
  end

endmodule

// ==== rv32i_writeback.sv ====
/* Register file and pc unit */
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module rv32i_writeback
  import rv32i_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset_n,
  decode_if.writeback            dec,
  input  logic [`XLEN-1:0]       alu_result,
  input  logic                   taken,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  output logic [`XLEN-1:0]       pc,
  output logic [`XLEN-1:0]       dmem_addr,
  output logic [`XLEN-1:0]       dmem_wdata,
  output logic                   dmem_we,
  input  logic [`XLEN-1:0]       dmem_rdata,
  output logic                   wb_en,
  output logic [`REG_ADDR_W-1:0] wb_addr,
  output logic [`XLEN-1:0]       wb_data
);

  logic [`XLEN-1:0] regs [1:31];  // x0 is not stored
  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] next_pc;

  assign rs1_data = (dec.rs1_addr == '0) ? '0 : regs[dec.rs1_addr];
  assign rs2_data = (dec.rs2_addr == '0) ? '0 : regs[dec.rs2_addr];

  assign pc_plus4 = pc + 32'd4;
  assign next_pc  = taken ? {alu_result[`XLEN-1:1], 1'b0} : pc_plus4;

  // Word store straight from rs2
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = reset_n && dec.mem_write;

  always_comb begin
    case (dec.wb_sel)
      WB_MEM:  wb_data = dmem_rdata;
      WB_LINK: wb_data = pc_plus4;     // Return address
      default: wb_data = alu_result;
    endcase
  end

  assign wb_en   = reset_n && dec.rf_wen && (dec.rd_addr != '0);
  assign wb_addr = dec.rd_addr;

  always_ff @(posedge clock) begin
    if (wb_en) begin
      regs[dec.rd_addr] <= wb_data;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      pc <= `RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  // A JALR target with bit 1 set would break this
  pc_word_aligned: assert property (@(posedge clock) disable iff (!reset_n)
    pc[1:0] == 2'b00)
    else $error("writeback: pc %h not word aligned", pc);

endmodule

// ==== rv32i_core.sv ====
/* Single cycle RV32I core */
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module rv32i_core (
  input  logic                   clock,
  input  logic                   reset_n,
  output logic [`XLEN-1:0]       imem_addr,
  input  logic [`XLEN-1:0]       imem_data,
  output logic [`XLEN-1:0]       dmem_addr,
  output logic [`XLEN-1:0]       dmem_wdata,
  output logic                   dmem_we,
  input  logic [`XLEN-1:0]       dmem_rdata,
  output logic                   wb_en,
  output logic [`REG_ADDR_W-1:0] wb_addr,
  output logic [`XLEN-1:0]       wb_data
);

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic [`XLEN-1:0] alu_result;
  logic             taken;

  decode_if dec_bus ();

  assign imem_addr = pc;  // Fetch address is the current pc

  rv32i_decoder u_decoder (
    .instr (imem_data),
    .dec   (dec_bus)
  );

  rv32i_executor u_executor (
    .dec        (dec_bus),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result),
    .taken      (taken)
  );

  rv32i_writeback u_writeback (
    .clock      (clock),
    .reset_n    (reset_n),
    .dec        (dec_bus),
    .alu_result (alu_result),
    .taken      (taken),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .pc         (pc),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .wb_en      (wb_en),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data)
  );

endmodule

// ==== tb_rv32i_core.sv ====
/* RV32I core testbench */
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module tb_rv32i_core;

  localparam int N_PROG = 43;
  localparam int N_WB   = 28;
  localparam int N_PC   = 37;
  localparam logic [31:0] LOOP_PC = 32'h0000_00A8;

  logic                   clock;
  logic                   reset_n;
  logic [`XLEN-1:0]       imem_addr;
  logic [`XLEN-1:0]       imem_data;
  logic [`XLEN-1:0]       dmem_addr;
  logic [`XLEN-1:0]       dmem_wdata;
  logic                   dmem_we;
  logic [`XLEN-1:0]       dmem_rdata;
  logic                   wb_en;
  logic [`REG_ADDR_W-1:0] wb_addr;
  logic [`XLEN-1:0]       wb_data;

  logic [31:0] imem [0:63];
  logic [31:0] dmem [0:63];
  logic [4:0]  exp_addr [0:N_WB-1];
  logic [31:0] exp_data [0:N_WB-1];
  logic [31:0] exp_pc [0:N_PC-1];
  int          wb_idx;
  int          cyc;
  int          st_cnt;
  logic [4:0]  addr_expect;
  logic [31:0] data_expect;
  logic [31:0] pc_expect;

  rv32i_core dut (.*);

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
    input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
    input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
    input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
    input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
  endfunction

  task automatic fail_now(input string msg);
    $display("error at %0t: %s", $time, msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Memory answers follow pc, then the data address
  initial begin
    @(posedge clock);
    #1 imem_data = imem[3];             // Register write offered during reset
    @(posedge clock);
    #1 imem_data = imem[23];            // Store offered during reset
    forever begin
      @(posedge clock);
      #1 imem_data = imem[imem_addr[7:2]];
      #1 dmem_rdata = dmem[dmem_addr[7:2]];
    end
  end

  always @(posedge clock) begin
    if (dmem_we) begin
      dmem[dmem_addr[7:2]] <= dmem_wdata;
    end
  end

  always @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      wb_idx <= 0;
      cyc    <= 0;
      st_cnt <= 0;
    end else begin
      cyc <= cyc + 1;
      if (wb_en) wb_idx <= wb_idx + 1;
      if (dmem_we) st_cnt <= st_cnt + 1;
    end
  end

  assign addr_expect = (wb_idx < N_WB) ? exp_addr[wb_idx] : 5'd0;
  assign data_expect = (wb_idx < N_WB) ? exp_data[wb_idx] : 32'd0;
  assign pc_expect   = (cyc < N_PC) ? exp_pc[cyc] : LOOP_PC;

  reset_quiet: assert property (@(posedge clock)
    (!reset_n || $rose(reset_n)) |-> (!wb_en && !dmem_we && imem_addr == `RESET_PC))
    else fail_now("outputs active or pc moved during reset");
  trace_match: assert property (@(posedge clock) disable iff (!reset_n)
    wb_en |-> (wb_idx < N_WB && wb_addr == addr_expect && wb_data == data_expect))
    else fail_now($sformatf("retire x%0d=%h, expected x%0d=%h",
                            wb_addr, wb_data, addr_expect, data_expect));
  pc_match: assert property (@(posedge clock) disable iff (!reset_n)
    imem_addr == pc_expect)
    else fail_now($sformatf("pc %h, expected %h", imem_addr, pc_expect));
  store_match: assert property (@(posedge clock) disable iff (!reset_n)
    dmem_we |-> (dmem_addr == 32'h1C && dmem_wdata == 32'h5))
    else fail_now($sformatf("store %h to %h", dmem_wdata, dmem_addr));

  initial begin
    #((3 + 20 * N_PROG) * 10);
    $display("timeout: the program never reached its final loop");
    $display("Finished with errors");
    $fatal(1);
  end

  initial begin
    reset_n    = 1'b0;
    imem_data  = '0;
    dmem_rdata = '0;
    void'($urandom(11));
    for (int i = 0; i < 64; i++) begin
      dmem[i] = $urandom;
      imem[i] = enc_i(12'(i), 5'd0, `F3_ADD, 5'd0, `OPC_OP_IMM);  // x0 filler tagged by index
    end
    imem[0]  = enc_i(12'd5, 5'd0, `F3_ADD, 5'd0, `OPC_OP_IMM);  // Writes x0
    imem[1]  = enc_i(-12'sd7, 5'd0, `F3_ADD, 5'd1, `OPC_OP_IMM);
    imem[2]  = enc_i(12'd12, 5'd0, `F3_ADD, 5'd2, `OPC_OP_IMM);
    imem[3]  = enc_r(7'h00, 5'd2, 5'd1, `F3_ADD, 5'd3);
    imem[4]  = enc_r(7'h20, 5'd1, 5'd2, `F3_ADD, 5'd4);           // SUB
    imem[5]  = enc_r(7'h00, 5'd2, 5'd2, `F3_SLL, 5'd5);
    imem[6]  = enc_r(7'h00, 5'd2, 5'd1, `F3_SLT, 5'd6);
    imem[7]  = enc_r(7'h00, 5'd2, 5'd1, `F3_SLTU, 5'd7);
    imem[8]  = enc_r(7'h00, 5'd2, 5'd1, `F3_XOR, 5'd8);
    imem[9]  = enc_r(7'h00, 5'd2, 5'd1, `F3_SR, 5'd9);
    imem[10] = enc_r(7'h20, 5'd2, 5'd1, `F3_SR, 5'd10);           // SRA
    imem[11] = enc_r(7'h00, 5'd2, 5'd1, `F3_OR, 5'd11);
    imem[12] = enc_r(7'h00, 5'd2, 5'd1, `F3_AND, 5'd12);
    imem[13] = enc_i(-12'sd6, 5'd1, `F3_SLT, 5'd13, `OPC_OP_IMM);
    imem[14] = enc_i(12'hFFF, 5'd2, `F3_SLTU, 5'd14, `OPC_OP_IMM);
    imem[15] = enc_i(12'h0F0, 5'd2, `F3_XOR, 5'd15, `OPC_OP_IMM);
    imem[16] = enc_i(12'h300, 5'd2, `F3_OR, 5'd16, `OPC_OP_IMM);
    imem[17] = enc_i(12'h07F, 5'd1, `F3_AND, 5'd17, `OPC_OP_IMM);
    imem[18] = enc_i(12'd4, 5'd2, `F3_SLL, 5'd18, `OPC_OP_IMM);
    imem[19] = enc_i(12'd28, 5'd1, `F3_SR, 5'd19, `OPC_OP_IMM);
    imem[20] = enc_i(12'h401, 5'd1, `F3_SR, 5'd20, `OPC_OP_IMM);  // SRAI by 1
    imem[21] = {20'h12345, 5'd21, `OPC_LUI};
    imem[22] = {20'h00001, 5'd22, `OPC_AUIPC};
    imem[23] = enc_s(12'd16, 5'd3, 5'd2);
    imem[24] = enc_i(12'd16, 5'd2, 3'b010, 5'd23, `OPC_LOAD);
    imem[25] = enc_i(12'd64, 5'd0, 3'b010, 5'd24, `OPC_LOAD);     // Untouched word
    imem[26] = enc_r(7'h00, 5'd4, 5'd0, `F3_ADD, 5'd25);
    imem[27] = enc_b(13'd8, 5'd2, 5'd1, `F3_BEQ);
    imem[28] = enc_b(13'd8, 5'd2, 5'd1, `F3_BNE);
    imem[29] = enc_i(12'd1, 5'd0, `F3_ADD, 5'd26, `OPC_OP_IMM);
    imem[30] = enc_b(13'd8, 5'd2, 5'd1, `F3_BLT);
    imem[31] = enc_i(12'd2, 5'd0, `F3_ADD, 5'd26, `OPC_OP_IMM);
    imem[32] = enc_b(13'd8, 5'd2, 5'd1, `F3_BGE);
    imem[33] = enc_b(13'd8, 5'd2, 5'd1, `F3_BLTU);
    imem[34] = enc_b(13'd8, 5'd2, 5'd1, `F3_BGEU);
    imem[35] = enc_i(12'd3, 5'd0, `F3_ADD, 5'd26, `OPC_OP_IMM);
    imem[36] = enc_j(21'd8, 5'd27);
    imem[37] = enc_i(12'd4, 5'd0, `F3_ADD, 5'd26, `OPC_OP_IMM);
    imem[38] = enc_i(12'h0A4, 5'd0, 3'b000, 5'd28, `OPC_JALR);
    imem[39] = enc_i(12'd5, 5'd0, `F3_ADD, 5'd26, `OPC_OP_IMM);
    imem[40] = enc_i(12'd6, 5'd0, `F3_ADD, 5'd26, `OPC_OP_IMM);
    imem[41] = enc_i(12'd1, 5'd27, `F3_ADD, 5'd29, `OPC_OP_IMM);
    imem[42] = enc_j(21'd0, 5'd0);                                // Final loop
    exp_addr = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10,
                 5'd11, 5'd12, 5'd13, 5'd14, 5'd15, 5'd16, 5'd17, 5'd18, 5'd19,
                 5'd20, 5'd21, 5'd22, 5'd23, 5'd24, 5'd25, 5'd27, 5'd28, 5'd29};
    exp_data = '{32'hFFFF_FFF9, 32'hC, 32'h5, 32'h13, 32'hC000, 32'h1, 32'h0,
                 32'hFFFF_FFF5, 32'h000F_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFD, 32'h8,
                 32'h1, 32'h1, 32'hFC, 32'h30C, 32'h79, 32'hC0, 32'hF, 32'hFFFF_FFFC,
                 32'h1234_5000, 32'h1058, 32'h5, 32'h0, 32'h13, 32'h94, 32'h9C, 32'h95};
    exp_data[23] = dmem[16];            // Preloaded word at 0x40
    for (int i = 0; i < 29; i++) exp_pc[i] = i * 4;
    exp_pc[29] = 32'h78;
    exp_pc[30] = 32'h80;
    exp_pc[31] = 32'h84;
    exp_pc[32] = 32'h88;
    exp_pc[33] = 32'h90;
    exp_pc[34] = 32'h98;
    exp_pc[35] = 32'hA4;
    exp_pc[36] = LOOP_PC;
    repeat (3) @(posedge clock);
    #1 reset_n = 1'b1;
    while (cyc < N_PC + 4) @(posedge clock);
    if (wb_idx == N_WB && st_cnt == 1) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("missing retirements or stores: %0d of %0d, %0d stores", wb_idx, N_WB, st_cnt);
      $display("Finished with errors");
      $fatal(1);
    end
  end

endmodule

// ==== rv32i_core.f ====
+incdir+.
rv32i_pkg.sv
decode_if.sv
rv32i_decoder.sv
rv32i_executor.sv
rv32i_writeback.sv
rv32i_core.sv
tb_rv32i_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv32i_core \
  -f rv32i_core.f -o sim_rv32i || exit 1
./obj_dir/sim_rv32i > sim.log 2>&1 || true
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log && echo "simulation passed" || exit 1
